//--- icache.f
+incdir+src
src/icache_addr_pkg.sv
src/icache_engine_pkg.sv
src/icache_if.sv
src/icache_sram.sv
src/icache_tag_lookup.sv
src/icache_tag_verify.sv
src/icache_miss_ctrl.sv
src/icache.sv
verif/icache_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 -f icache.f --top-module icache_tb
./obj_dir/Vicache_tb | tee sim.log

if grep -q "Test completed successfully" sim.log; then
  exit 0
else
  exit 1
fi

//--- src/icache.sv
`timescale 1ns/10ps

module icache
  (
    input  logic                      clk_i,
    input  logic                      reset_i,

    // Decode
    input  logic                      fetch_v_i,
    input  icache_addr_pkg::vaddr_t   fetch_vaddr_i,
    output logic                      fetch_yumi_o,

    // Tag lookup
    input  icache_addr_pkg::ptag_t    ptag_i,
    input  logic                      ptag_v_i,
    output logic                      tl_v_o,
    output icache_addr_pkg::vaddr_t   tl_vaddr_o,

    // Tag verify
    output icache_addr_pkg::instr_t   data_o,
    output logic                      miss_o,
    output logic                      data_v_o,
    input  logic                      data_yumi_i,

    // Miss engine
    output logic                      req_v_o,
    output icache_engine_pkg::paddr_t req_paddr_o,
    output icache_addr_pkg::way_t     req_way_o,
    input  logic                      req_ready_i,
    input  logic                      fill_v_i,
    input  icache_addr_pkg::block_t   fill_block_i
  );

  tl_tv_if   tl_tv ();
  tv_miss_if tv_miss ();
  fill_if    fill ();

  icache_tag_lookup tag_lookup
  (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_v_i     (fetch_v_i),
    .fetch_vaddr_i (fetch_vaddr_i),
    .fetch_yumi_o  (fetch_yumi_o),
    .tl_o          (tl_tv.tl),
    .fill          (fill.lookup)
  );

  icache_tag_verify tag_verify
  (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .tl_i        (tl_tv.tv),
    .ptag_i      (ptag_i),
    .ptag_v_i    (ptag_v_i),
    .data_yumi_i (data_yumi_i),
    .data_o      (data_o),
    .miss_o      (miss_o),
    .data_v_o    (data_v_o),
    .tv_o        (tv_miss.source)
  );

  icache_miss_ctrl miss_ctrl
  (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .tv_i         (tv_miss.sink),
    .data_yumi_i  (data_yumi_i),
    .req_ready_i  (req_ready_i),
    .req_v_o      (req_v_o),
    .req_paddr_o  (req_paddr_o),
    .req_way_o    (req_way_o),
    .fill_v_i     (fill_v_i),
    .fill_block_i (fill_block_i),
    .fill_o       (fill.source),
    .tl_v_i       (tl_tv.tl_v)
  );

  assign tl_v_o     = tl_tv.tl_v;
  assign tl_vaddr_o = tl_tv.tl_vaddr;

endmodule

//--- src/icache_addr_pkg.sv
`include "icache_config.svh"

package icache_addr_pkg;

  // Derived field widths
  localparam int unsigned BLOCK_OFF_W = $clog2(`ICACHE_BLOCK_W / 8);
  localparam int unsigned INDEX_W     = $clog2(`ICACHE_SETS);
  localparam int unsigned WAY_W       = $clog2(`ICACHE_WAYS);
  localparam int unsigned WORD_SEL_W  = $clog2(`ICACHE_BLOCK_W / `ICACHE_INSTR_W);
  localparam int unsigned WORD_LSB    = $clog2(`ICACHE_INSTR_W / 8);

  typedef logic [`ICACHE_VADDR_W-1:0] vaddr_t;
  typedef logic [`ICACHE_PTAG_W-1:0]  ptag_t;
  typedef logic [INDEX_W-1:0]         index_t;
  typedef logic [WORD_SEL_W-1:0]      word_sel_t;
  typedef logic [WAY_W-1:0]           way_t;
  typedef logic [`ICACHE_WAYS-1:0]    way_mask_t;
  typedef logic [`ICACHE_INSTR_W-1:0] instr_t;

  // Word 0 sits in the low bits
  typedef logic [`ICACHE_BLOCK_W-1:0] block_t;

  // One entry per way, way 0 in the low bits
  typedef ptag_t  [`ICACHE_WAYS-1:0] tag_row_t;
  typedef block_t [`ICACHE_WAYS-1:0] data_row_t;

endpackage

//--- src/icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// Address geometry
`define ICACHE_VADDR_W     32
`define ICACHE_PTAG_W      20
`define ICACHE_PAGE_OFF_W  12

// Cache organization
`define ICACHE_SETS        64
`define ICACHE_WAYS        2

// One block is filled in a single beat
`define ICACHE_BLOCK_W     128

// Fetch granule
`define ICACHE_INSTR_W     32

`endif

//--- src/icache_engine_pkg.sv
`include "icache_config.svh"

package icache_engine_pkg;

  // Miss handling states
  //   e_ready   : fetches may be accepted, a TV miss may be requested
  //   e_miss    : request sent, waiting for the fill
  //   e_recover : re-read the TL index after a fill
  typedef enum logic [1:0]
  {
    e_ready   = 2'd0,
    e_miss    = 2'd1,
    e_recover = 2'd2
  } miss_state_e;

  // Physical address toward the engine
  typedef logic [`ICACHE_PTAG_W+`ICACHE_PAGE_OFF_W-1:0] paddr_t;

endpackage

//--- src/icache_if.sv
`timescale 1ns/10ps

// Tag lookup to tag verify
interface tl_tv_if;
  import icache_addr_pkg::*;
  logic      tl_v;
  vaddr_t    tl_vaddr;
  tag_row_t  tag_row;
  data_row_t data_row;
  way_mask_t way_valid;
  logic      tv_we;

  modport tl (output tl_v, tl_vaddr, tag_row, data_row, way_valid, input tv_we);
  modport tv (input tl_v, tl_vaddr, tag_row, data_row, way_valid, output tv_we);
endinterface

// Tag verify to miss control
interface tv_miss_if;
  import icache_addr_pkg::*;
  import icache_engine_pkg::*;
  logic      tv_v;
  logic      tv_hit;
  way_t      hit_way;
  index_t    tv_index;
  paddr_t    tv_paddr;
  way_mask_t tv_way_valid;

  modport source (output tv_v, tv_hit, hit_way, tv_index, tv_paddr, tv_way_valid);
  modport sink (input tv_v, tv_hit, hit_way, tv_index, tv_paddr, tv_way_valid);
endinterface

// Miss control to tag lookup
interface fill_if;
  import icache_addr_pkg::*;
  logic   fill_we;
  index_t fill_index;
  way_t   fill_way;
  ptag_t  fill_tag;
  block_t fill_block;
  logic   recover_rd;
  logic   accept_ok;

  modport source (output fill_we, fill_index, fill_way, fill_tag, fill_block,
                  recover_rd, accept_ok);
  modport lookup (input fill_we, fill_index, fill_way, fill_tag, fill_block,
                  recover_rd, accept_ok);
endinterface

//--- src/icache_miss_ctrl.sv
`timescale 1ns/10ps

`include "icache_config.svh"

module icache_miss_ctrl
  (
    input  logic                      clk_i,
    input  logic                      reset_i,
    tv_miss_if.sink                   tv_i,
    input  logic                      data_yumi_i,
    input  logic                      req_ready_i,
    output logic                      req_v_o,
    output icache_engine_pkg::paddr_t req_paddr_o,
    output icache_addr_pkg::way_t     req_way_o,
    input  logic                      fill_v_i,
    input  icache_addr_pkg::block_t   fill_block_i,
    fill_if.source                    fill_o,
    input  logic                      tl_v_i
  );
  import icache_addr_pkg::*;
  import icache_engine_pkg::*;

  miss_state_e state_r;
  miss_state_e state_n;
  logic        req_sent_r;
  logic        lru_r [2**INDEX_W];
  way_t        repl_way;
  index_t      fill_index_r;
  way_t        fill_way_r;
  ptag_t       fill_tag_r;

  //////////////////////////////////////////////////////////////////////
  // Request and replacement
  //////////////////////////////////////////////////////////////////////
  // Lowest invalid way first, else the LRU way of the set
  always_comb
  begin
    repl_way = way_t'(lru_r[tv_i.tv_index]);
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--)
      if (!tv_i.tv_way_valid[w])
        repl_way = way_t'(w);
  end

  assign req_v_o     = (state_r == e_ready) & tv_i.tv_v & ~tv_i.tv_hit & ~req_sent_r
                       & req_ready_i;
  assign req_paddr_o = {tv_i.tv_paddr[$bits(paddr_t)-1:BLOCK_OFF_W], {BLOCK_OFF_W{1'b0}}};
  assign req_way_o   = repl_way;

  // One request per TV miss, even if the miss result lingers
  always_ff @(posedge clk_i)
  begin
    if (reset_i || data_yumi_i)
      req_sent_r <= 1'b0;
    else if (req_v_o)
      req_sent_r <= 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (req_v_o)
    begin
      fill_index_r <= tv_i.tv_index;
      fill_way_r   <= repl_way;
      fill_tag_r   <= tv_i.tv_paddr[$bits(paddr_t)-1 -: $bits(ptag_t)];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    case (state_r)
      e_ready:   state_n = req_v_o ? e_miss : e_ready;
      e_miss:    state_n = fill_v_i ? (tl_v_i ? e_recover : e_ready) : e_miss;
      e_recover: state_n = e_ready;
      default:   state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_ready;
    else
      state_r <= state_n;
  end

  assign fill_o.fill_we    = fill_v_i & (state_r == e_miss);
  assign fill_o.fill_index = fill_index_r;
  assign fill_o.fill_way   = fill_way_r;
  assign fill_o.fill_tag   = fill_tag_r;
  assign fill_o.fill_block = fill_block_i;
  assign fill_o.recover_rd = (state_r == e_recover);
  // Accepting also needs the engine side able to take a request
  assign fill_o.accept_ok  = (state_r == e_ready) & req_ready_i;

  // LRU bit names the way not just used; a fill wins over a hit
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int s = 0; s < 2**INDEX_W; s++)
        lru_r[s] <= 1'b0;
    end
    else
    begin
      if (tv_i.tv_v && tv_i.tv_hit && data_yumi_i)
        lru_r[tv_i.tv_index] <= ~tv_i.hit_way[0];
      if (fill_o.fill_we)
        lru_r[fill_index_r] <= ~fill_way_r[0];
    end
  end

  a_fill_in_miss: assert property (@(posedge clk_i) disable iff (reset_i)
    fill_v_i |-> (state_r == e_miss));

endmodule

//--- src/icache_sram.sv
`timescale 1ns/10ps

module icache_sram
  #(parameter type row_t = icache_addr_pkg::tag_row_t)
  (
    input  logic                        clk_i,
    input  logic                        v_i,
    input  logic                        w_i,
    input  icache_addr_pkg::index_t     addr_i,
    input  row_t                        data_i,
    input  icache_addr_pkg::way_mask_t  mask_i,
    output row_t                        data_o
  );
  import icache_addr_pkg::*;

  localparam int unsigned ROW_W   = $bits(row_t);
  localparam int unsigned WAYS    = $bits(way_mask_t);
  localparam int unsigned SLICE_W = ROW_W / WAYS;
  localparam int unsigned DEPTH   = 2 ** $bits(index_t);

  logic [ROW_W-1:0] mem_r [DEPTH];
  logic [ROW_W-1:0] rd_r;
  logic [ROW_W-1:0] wr_bits;

  assign wr_bits = data_i;

  // Per-way write; the read register keeps its value between reads
  always_ff @(posedge clk_i)
  begin
    if (w_i)
    begin
      for (int w = 0; w < WAYS; w++)
        if (mask_i[w])
          mem_r[addr_i][w*SLICE_W +: SLICE_W] <= wr_bits[w*SLICE_W +: SLICE_W];
    end
    if (v_i)
      rd_r <= mem_r[addr_i];
  end

  assign data_o = row_t'(rd_r);

  // Single port, so a read and a write cannot share a cycle
  a_one_port: assert property (@(posedge clk_i) !(v_i && w_i));

endmodule

//--- src/icache_tag_lookup.sv
`timescale 1ns/10ps

`include "icache_config.svh"

module icache_tag_lookup
  (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    fetch_v_i,
    input  icache_addr_pkg::vaddr_t fetch_vaddr_i,
    output logic                    fetch_yumi_o,
    tl_tv_if.tl                     tl_o,
    fill_if.lookup                  fill
  );
  import icache_addr_pkg::*;

  logic      tl_v_r;
  vaddr_t    tl_vaddr_r;
  way_mask_t valid_r [2**INDEX_W];
  way_mask_t way_valid_r;
  logic      advance;
  logic      rd_v;
  index_t    rd_index;
  index_t    mem_addr;
  way_mask_t fill_mask;

  //////////////////////////////////////////////////////////////////////
  // Acceptance and TL registers
  //////////////////////////////////////////////////////////////////////
  assign advance      = tl_v_r & tl_o.tv_we;
  assign fetch_yumi_o = fetch_v_i & fill.accept_ok & (~tl_v_r | advance);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tl_v_r <= 1'b0;
    else if (fetch_yumi_o)
      tl_v_r <= 1'b1;
    else if (advance)
      tl_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (fetch_yumi_o)
      tl_vaddr_r <= fetch_vaddr_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Array control
  //////////////////////////////////////////////////////////////////////
  // Recover re-reads the index that is already sitting in TL
  assign rd_v      = fetch_yumi_o | fill.recover_rd;
  assign rd_index  = fetch_yumi_o ? fetch_vaddr_i[BLOCK_OFF_W +: INDEX_W]
                                  : tl_vaddr_r[BLOCK_OFF_W +: INDEX_W];
  assign mem_addr  = fill.fill_we ? fill.fill_index : rd_index;
  assign fill_mask = way_mask_t'(1) << fill.fill_way;

  icache_sram #(.row_t(tag_row_t)) tag_mem
  (
    .clk_i  (clk_i),
    .v_i    (rd_v),
    .w_i    (fill.fill_we),
    .addr_i (mem_addr),
    .data_i ({`ICACHE_WAYS{fill.fill_tag}}),
    .mask_i (fill_mask),
    .data_o (tl_o.tag_row)
  );

  icache_sram #(.row_t(data_row_t)) data_mem
  (
    .clk_i  (clk_i),
    .v_i    (rd_v),
    .w_i    (fill.fill_we),
    .addr_i (mem_addr),
    .data_i ({`ICACHE_WAYS{fill.fill_block}}),
    .mask_i (fill_mask),
    .data_o (tl_o.data_row)
  );

  // Valid bits live in flops and are read alongside the arrays
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int s = 0; s < 2**INDEX_W; s++)
        valid_r[s] <= '0;
      way_valid_r <= '0;
    end
    else
    begin
      if (fill.fill_we)
        valid_r[fill.fill_index] <= valid_r[fill.fill_index] | fill_mask;
      if (rd_v)
        way_valid_r <= valid_r[rd_index];
    end
  end

  assign tl_o.tl_v      = tl_v_r;
  assign tl_o.tl_vaddr  = tl_vaddr_r;
  assign tl_o.way_valid = way_valid_r;

  // Fills only land outside the ready state, so they never meet an accept
  a_fill_accept: assert property (@(posedge clk_i) disable iff (reset_i)
    !(fill.fill_we && fetch_yumi_o));

endmodule

//--- src/icache_tag_verify.sv
`timescale 1ns/10ps

`include "icache_config.svh"

module icache_tag_verify
  (
    input  logic                    clk_i,
    input  logic                    reset_i,
    tl_tv_if.tv                     tl_i,
    input  icache_addr_pkg::ptag_t  ptag_i,
    input  logic                    ptag_v_i,
    input  logic                    data_yumi_i,
    output icache_addr_pkg::instr_t data_o,
    output logic                    miss_o,
    output logic                    data_v_o,
    tv_miss_if.source               tv_o
  );
  import icache_addr_pkg::*;
  import icache_engine_pkg::*;

  logic      tv_v_r;
  logic      advance;
  way_mask_t hit_c;
  way_t      hit_way_c;
  way_mask_t hit_r;
  way_t      hit_way_r;
  block_t    block_r;
  paddr_t    paddr_r;
  way_mask_t way_valid_r;
  word_sel_t word_sel;

  // Stage may load when empty or draining, once the translation is present
  assign tl_i.tv_we = (~tv_v_r | data_yumi_i) & ptag_v_i;
  assign advance    = tl_i.tv_we & tl_i.tl_v;

  //////////////////////////////////////////////////////////////////////
  // Tag compare
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    hit_way_c = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      hit_c[w] = tl_i.way_valid[w] & (tl_i.tag_row[w] == ptag_i);
      if (hit_c[w])
        hit_way_c = way_t'(w);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tv_v_r <= 1'b0;
    else if (advance)
      tv_v_r <= 1'b1;
    else if (data_yumi_i)
      tv_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      hit_r <= '0;
    else if (advance)
      hit_r <= hit_c;
  end

  always_ff @(posedge clk_i)
  begin
    if (advance)
    begin
      hit_way_r   <= hit_way_c;
      block_r     <= tl_i.data_row[hit_way_c];
      paddr_r     <= {ptag_i, tl_i.tl_vaddr[`ICACHE_PAGE_OFF_W-1:0]};
      way_valid_r <= tl_i.way_valid;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result
  //////////////////////////////////////////////////////////////////////
  assign word_sel = paddr_r[WORD_LSB +: WORD_SEL_W];
  assign data_o   = block_r[word_sel*`ICACHE_INSTR_W +: `ICACHE_INSTR_W];
  assign data_v_o = tv_v_r;
  assign miss_o   = tv_v_r & ~(|hit_r);

  assign tv_o.tv_v         = tv_v_r;
  assign tv_o.tv_hit       = |hit_r;
  assign tv_o.hit_way      = hit_way_r;
  assign tv_o.tv_index     = paddr_r[BLOCK_OFF_W +: INDEX_W];
  assign tv_o.tv_paddr     = paddr_r;
  assign tv_o.tv_way_valid = way_valid_r;

  // A block never sits in two ways of one set
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    tv_v_r |-> $onehot0(hit_r));

endmodule

//--- verif/icache_tb.sv
`timescale 1ns/10ps

module icache_tb;
  import icache_addr_pkg::*;
  import icache_engine_pkg::*;

  // Three blocks that share set index 4 but differ in page
  localparam vaddr_t BLK_A = 32'h0000_1040;
  localparam vaddr_t BLK_B = 32'h0000_5040;
  localparam vaddr_t BLK_C = 32'h0000_9040;

  logic   clk_i;
  logic   reset_i;
  logic   fetch_v_i;
  vaddr_t fetch_vaddr_i;
  logic   fetch_yumi_o;
  ptag_t  ptag_i;
  logic   ptag_v_i;
  logic   tl_v_o;
  vaddr_t tl_vaddr_o;
  instr_t data_o;
  logic   miss_o;
  logic   data_v_o;
  logic   data_yumi_i;
  logic   req_v_o;
  paddr_t req_paddr_o;
  way_t   req_way_o;
  logic   req_ready_i;
  logic   fill_v_i;
  block_t fill_block_i;

  int          errors;
  int          timeouts;
  logic [31:0] lfsr_r;
  block_t      fill_mem [paddr_t];
  logic        seen_req;
  paddr_t      seen_paddr;
  way_t        seen_way;

  icache icache_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Translation model that follows whatever sits in TL
  initial
  begin
    ptag_i   = '0;
    ptag_v_i = 1'b0;
    forever
    begin
      @(posedge clk_i);
      #1;
      ptag_v_i = tl_v_o;
      ptag_i   = tl_vaddr_o[31:12] ^ 20'h0A5A5;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference helpers
  //////////////////////////////////////////////////////////////////////
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic paddr_t block_addr(input vaddr_t va);
    paddr_t pa;
    pa      = {va[31:12] ^ 20'h0A5A5, va[11:0]};
    pa[3:0] = '0;
    return pa;
  endfunction

  function automatic instr_t expected_word(input vaddr_t va);
    block_t blk;
    int     w;
    blk = '0;
    if (fill_mem.exists(block_addr(va)))
      blk = fill_mem[block_addr(va)];
    w = int'(va[3:2]);
    return blk[w*$bits(instr_t) +: $bits(instr_t)];
  endfunction

  task automatic check_instr(input string name, input instr_t got, input instr_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_miss(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_paddr(input string name, input paddr_t got, input paddr_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_way(input string name, input way_t got, input way_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_vaddr(input string name, input vaddr_t got, input vaddr_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus tasks
  //////////////////////////////////////////////////////////////////////
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  // Handshakes are sampled mid-cycle and complete on the next edge
  task automatic wait_accept();
    int n = 0;
    @(negedge clk_i);
    while (!fetch_yumi_o && n < 100)
    begin
      n++;
      @(negedge clk_i);
    end
    if (!fetch_yumi_o)
    begin
      timeouts++;
      $display("Timed out waiting for the cache to accept a fetch");
    end
    step();
  endtask

  task automatic wait_result(output instr_t instr, output logic miss, output int cycles);
    cycles = 1;
    @(negedge clk_i);
    while (!data_v_o && cycles < 100)
    begin
      cycles++;
      @(negedge clk_i);
    end
    if (!data_v_o)
    begin
      timeouts++;
      $display("Timed out waiting for a fetch result");
    end
    instr      = data_o;
    miss       = miss_o;
    seen_req   = req_v_o;
    seen_paddr = req_paddr_o;
    seen_way   = req_way_o;
    step();
  endtask

  // Engine model that answers each request with one random block
  task automatic serve_fill(input paddr_t pa);
    block_t blk;
    repeat (3) step();
    for (int i = 0; i < $bits(block_t); i++)
    begin
      lfsr_r = lfsr_next(lfsr_r);
      blk[i] = lfsr_r[0];
    end
    fill_mem[pa] = blk;
    fill_v_i     = 1'b1;
    fill_block_i = blk;
    step();
    fill_v_i = 1'b0;
  endtask

  task automatic fetch_once(input vaddr_t va, output instr_t instr, output logic miss,
                            output int cycles);
    fetch_v_i     = 1'b1;
    fetch_vaddr_i = va;
    wait_accept();
    fetch_v_i = 1'b0;
    // The accepted fetch now sits in TL
    check_miss("tl_v_o", tl_v_o, 1'b1);
    check_vaddr("tl_vaddr_o", tl_vaddr_o, va);
    wait_result(instr, miss, cycles);
  endtask

  task automatic expect_miss(input vaddr_t va, input way_t exp_way);
    instr_t instr;
    logic   miss;
    int     cycles;
    fetch_once(va, instr, miss, cycles);
    check_miss("miss_o", miss, 1'b1);
    if (!seen_req)
    begin
      errors++;
      $display("No refill request was issued for the miss at address %h", va);
    end
    else
    begin
      check_paddr("req_paddr_o", seen_paddr, block_addr(va));
      check_way("req_way_o", seen_way, exp_way);
      serve_fill(block_addr(va));
    end
  endtask

  task automatic expect_hit(input vaddr_t va);
    instr_t instr;
    logic   miss;
    int     cycles;
    fetch_once(va, instr, miss, cycles);
    check_miss("miss_o", miss, 1'b0);
    check_instr("data_o", instr, expected_word(va));
    if (cycles != 2)
    begin
      errors++;
      $display("Hit at address %h took %0d cycles after acceptance instead of 2", va, cycles);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////
  task automatic run_reset_checks();
    @(negedge clk_i);
    check_miss("data_v_o", data_v_o, 1'b0);
    check_miss("req_v_o", req_v_o, 1'b0);
    check_miss("tl_v_o", tl_v_o, 1'b0);
    step();
    // Way 0 is the lowest invalid way of an empty set
    expect_miss(BLK_A, way_t'(0));
  endtask

  task automatic refetch_filled_block();
    for (int w = 0; w < 4; w++)
      expect_hit(BLK_A + vaddr_t'(4 * w));
  endtask

  task automatic fill_second_way();
    expect_miss(BLK_B, way_t'(1));
    expect_hit(BLK_B + 4);
    expect_hit(BLK_A + 8);
  endtask

  // A hit on way 0 leaves way 1 as the LRU way
  task automatic replace_lru_way();
    expect_hit(BLK_A);
    expect_miss(BLK_C, way_t'(1));
    expect_hit(BLK_C + 12);
    expect_hit(BLK_A + 4);
    expect_miss(BLK_B, way_t'(1));
    expect_hit(BLK_A);
  endtask

  task automatic hold_under_backpressure();
    instr_t instr;
    logic   miss;
    int     cycles;
    data_yumi_i   = 1'b0;
    fetch_v_i     = 1'b1;
    fetch_vaddr_i = BLK_A + 4;
    wait_accept();
    fetch_vaddr_i = BLK_B + 8;
    wait_accept();
    // A third fetch stays pending behind the full pipe
    fetch_vaddr_i = BLK_C;
    for (int i = 0; i < 10; i++)
    begin
      @(negedge clk_i);
      check_miss("data_v_o", data_v_o, 1'b1);
      check_instr("data_o", data_o, expected_word(BLK_A + 4));
      check_miss("fetch_yumi_o", fetch_yumi_o, 1'b0);
      step();
    end
    fetch_v_i   = 1'b0;
    data_yumi_i = 1'b1;
    wait_result(instr, miss, cycles);
    check_miss("miss_o", miss, 1'b0);
    check_instr("data_o", instr, expected_word(BLK_A + 4));
    wait_result(instr, miss, cycles);
    check_miss("miss_o", miss, 1'b0);
    check_instr("data_o", instr, expected_word(BLK_B + 8));
  endtask

  initial
  begin
    errors        = 0;
    timeouts      = 0;
    lfsr_r        = 32'hff31316e;
    reset_i       = 1'b1;
    fetch_v_i     = 1'b0;
    fetch_vaddr_i = '0;
    data_yumi_i   = 1'b1;
    req_ready_i   = 1'b1;
    fill_v_i      = 1'b0;
    fill_block_i  = '0;
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    run_reset_checks();
    if (timeouts == 0)
      refetch_filled_block();
    if (timeouts == 0)
      fill_second_way();
    if (timeouts == 0)
      replace_lru_way();
    if (timeouts == 0)
      hold_under_backpressure();

    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule
